// ==== sim/cnn_test_stimulus.txt ====
# W addr data                 host write, 7-bit address and 16-bit data in hex
# R addr reply word           host read, 31-bit reply (bit 0 sampled first), expected readback
# N regions dbg_valid dbg_data   run header, one C line per region follows
# C bytes                     20 class bytes in hex, leftmost byte driven first
W 3a 8000
W 05 a5c3
W 7f 1234
W 00 0001
R 3a 61d29b2d c3a5
R 12 0000ffff 0001
R 40 40000000 8000
R 7f 7fff8000 ffff
# two regions, both selects set
N 2 1 1
C 1f2e3d4c5b6a79880796a5b4c3d2e1f00fe1d2c3
C a0b1c2d3e4f5061728394a5b6c7d8e9fff00ee11
W 2c 0f0f
# one region, plain run mode
N 1 0 0
C 55aa33cc0ff0123456789abcdef0fedcba987654
R 21 61d29b2d c3a5
# one region, debug-data mode
N 1 0 1
C 8182838485868788898a8b8c8d8e8f9091929394
W 01 beef
W 3a 0137

// ==== files.f ====
design/cnn_test_pkg.sv
design/spi_config_shifter.sv
design/readout_sequencer.sv
design/settle_timer.sv
design/class_result_buffer.sv
design/cnn_test_top.sv
sim/cnn_test_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = cnn_test_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/cnn_test_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_test_tb;

    import cnn_test_pkg::*;

    localparam int NUM_CLASS = 20;
    localparam int TIMEOUT   = 200;
    localparam int EV_READY  = 0;
    localparam int EV_DONE   = 1;
    localparam int EV_LAST   = 2;

    logic        clk = 1'b0;
    logic        reset;
    host_ctrl_t  host_ctrl;
    spi_cmd_t    host_cmd;
    logic        cnn_ready;
    logic        cnn_done;
    logic        last_region;
    class_byte_t class_byte;
    logic        spi_out;
    logic        result_rd;
    chip_spi_t   chip_spi;
    logic [15:0] spi_rdata;
    logic        seq_busy;
    logic        results_ready;
    class_byte_t result_data;

    // decoded frames written by the deserializer below
    logic [FRAME_BITS-1:0] rx_sr;
    cfg_frame_t            frames [1024];
    int                    frame_wr = 0;
    int                    frame_rd = 0;

    // every byte the stand-in has handed over in store order
    class_byte_t model [$];
    class_byte_t run_bytes [$];
    integer      seed;

    cnn_test_top #(
        .NUM_CLASS_BYTES (NUM_CLASS),
        .SETTLE_CYCLES   (28),
        .BUFFER_DEPTH    (2048)
    ) cnn_test_top_i (
        .clk           (clk),
        .reset         (reset),
        .host_ctrl     (host_ctrl),
        .host_cmd      (host_cmd),
        .cnn_ready     (cnn_ready),
        .cnn_done      (cnn_done),
        .last_region   (last_region),
        .class_byte    (class_byte),
        .spi_out       (spi_out),
        .result_rd     (result_rd),
        .chip_spi      (chip_spi),
        .spi_rdata     (spi_rdata),
        .seq_busy      (seq_busy),
        .results_ready (results_ready),
        .result_data   (result_data)
    );

    // 40 ns period
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // frame decoder
    ////////////////////////////////////////////////////////////////////////////

    // last 23 sdi samples lsb first and frozen by the update strobe
    always @(posedge clk) begin
        if (chip_spi.update) begin
            frames[frame_wr] <= rx_sr;
            frame_wr         <= frame_wr + 1;
        end
        rx_sr <= {chip_spi.sdi, rx_sr[FRAME_BITS-1:1]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // check helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("ERR %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_fields(input integer got, input integer want);
        assert (got == want) else begin
            $display("malformed record in the stimulus file");
            abort_run();
        end
    endtask

    // serial pins and status must all be quiet
    task automatic check_quiet_outputs();
        check_value("chip_spi.sdi", chip_spi.sdi, 0);
        check_value("chip_spi.update", chip_spi.update, 0);
        check_value("chip_spi.capture", chip_spi.capture, 0);
        check_value("seq_busy", seq_busy, 0);
        check_value("results_ready", results_ready, 0);
        check_value("spi_rdata", spi_rdata, 0);
    endtask

    // waits with a timeout for the next decoded frame
    task automatic expect_frame(input logic [6:0] addr, input logic [15:0] data,
                                input logic busy);
        int waited;
        waited = 0;
        while (frame_rd == frame_wr) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout waiting for a configuration frame");
                abort_run();
            end
        end
        check_value("frame.addr", frames[frame_rd].addr, addr);
        check_value("frame.data", frames[frame_rd].data, data);
        check_value("seq_busy", seq_busy, busy);
        frame_rd++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////////////

    // command strobe at edge N then bit k after edge N+k and the strobe after N+23
    task automatic issue_host_cmd(input spi_cmd_t cmd);
        logic [FRAME_BITS-1:0] bits;
        int                    k;
        bits = cmd.rd ? {16'd0, cmd.frame.addr} : cmd.frame;
        @(posedge clk);
        host_cmd <= cmd;
        @(posedge clk);
        host_cmd <= '0;
        for (k = 0; k < FRAME_BITS; k++) begin
            @(posedge clk);
            check_value("chip_spi.sdi", chip_spi.sdi, bits[k]);
            check_value("chip_spi.update", chip_spi.update, 0);
            check_value("chip_spi.capture", chip_spi.capture, 0);
        end
        @(posedge clk);
        check_value("chip_spi.update", chip_spi.update, cmd.wr);
        check_value("chip_spi.capture", chip_spi.capture, cmd.rd);
    endtask

    task automatic write_register(input logic [6:0] addr, input logic [15:0] data);
        spi_cmd_t cmd;
        cmd            = '0;
        cmd.wr         = 1'b1;
        cmd.frame.addr = addr;
        cmd.frame.data = data;
        issue_host_cmd(cmd);
        expect_frame(addr, data, 1'b0);
    endtask

    // reply bit 0 is the first sample and readback is the last 16 samples
    task automatic read_register(input logic [6:0] addr, input logic [30:0] reply,
                                 input logic [15:0] word);
        spi_cmd_t cmd;
        int       i;
        assert (word == reply[30:15]) else begin
            $display("read record expects a word that its reply does not hold");
            abort_run();
        end
        cmd            = '0;
        cmd.rd         = 1'b1;
        cmd.frame.addr = addr;
        issue_host_cmd(cmd);
        // capture seen on this edge so samples start on the next one
        for (i = 0; i < READ_BITS; i++) begin
            spi_out <= reply[i];
            @(posedge clk);
        end
        spi_out <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("spi_rdata", spi_rdata, word);
    endtask

    // entry k-1 shows one cycle after the k-th read edge
    task automatic read_results(input int n);
        int k;
        @(posedge clk);
        result_rd <= 1'b1;
        for (k = 0; k <= n; k++) begin
            @(posedge clk);
            if (k == n - 1) begin
                result_rd <= 1'b0;
            end
            if (k >= 1) begin
                check_value("result_data", result_data, model[k-1]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // chip stand-in
    ////////////////////////////////////////////////////////////////////////////

    // at least 30 cycles after the last decoded frame
    task automatic chip_event(input int kind);
        int gap;
        gap = ($random(seed) & 7) + 30;
        repeat (gap) @(posedge clk);
        case (kind)
            EV_READY: cnn_ready <= 1'b1;
            EV_DONE:  cnn_done <= 1'b1;
            default:  last_region <= 1'b1;
        endcase
        @(posedge clk);
        cnn_ready   <= 1'b0;
        cnn_done    <= 1'b0;
        last_region <= 1'b0;
    endtask

    task automatic run_regions(input int regions, input logic dv, input logic dd);
        logic [15:0] sel;
        int          r;
        int          i;
        int          waited;
        // debug-valid has priority over debug-data
        sel = dv ? MODE_DBG_VALID : (dd ? MODE_DBG_DATA : MODE_RUN);
        @(posedge clk);
        host_ctrl <= '{start: 1'b1, dbg_valid: dv, dbg_data: dd};
        expect_frame(MODE_REG_ADDR, MODE_RUN, 1'b1);
        chip_event(EV_READY);
        for (r = 0; r < regions; r++) begin
            expect_frame(MODE_REG_ADDR, sel, 1'b1);
            chip_event(EV_DONE);
            expect_frame(MODE_REG_ADDR, MODE_RUN, 1'b1);
            chip_event((r == regions - 1) ? EV_LAST : EV_READY);
            for (i = 0; i < NUM_CLASS; i++) begin
                expect_frame(MODE_REG_ADDR, 16'(i), 1'b1);
                class_byte <= run_bytes[r*NUM_CLASS + i];
                model.push_back(run_bytes[r*NUM_CLASS + i]);
            end
        end
        waited = 0;
        while (!results_ready) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout waiting for results_ready");
                abort_run();
            end
        end
        // drop start so the sequencer stays in idle
        host_ctrl <= '0;
        check_value("seq_busy", seq_busy, 1);
        @(posedge clk);
        check_value("results_ready", results_ready, 1);
        check_value("seq_busy", seq_busy, 0);
        @(posedge clk);
        check_value("results_ready", results_ready, 0);
        check_value("seq_busy", seq_busy, 0);
        check_value("unexpected frames", frame_wr - frame_rd, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        string          line;
        integer         fd;
        integer         code;
        logic [6:0]     addr;
        logic [15:0]    data;
        logic [30:0]    reply;
        logic [159:0]   row;
        int             regions;
        logic           dv;
        logic           dd;
        int             i;
        reset       = 1'b1;
        host_ctrl   = '0;
        host_cmd    = '0;
        cnn_ready   = 1'b0;
        cnn_done    = 1'b0;
        last_region = 1'b0;
        class_byte  = '0;
        spi_out     = 1'b0;
        result_rd   = 1'b0;
        seed        = 32'he2e3;
        regions     = 0;
        dv          = 1'b0;
        dd          = 1'b0;

        // outputs are settled once the first edge has applied the reset
        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            check_quiet_outputs();
        end
        reset <= 1'b0;
        @(posedge clk);
        check_quiet_outputs();

        fd = $fopen("sim/cnn_test_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            case (line[0])
                "W": begin
                    code = $sscanf(line, "W %h %h", addr, data);
                    check_fields(code, 2);
                    write_register(addr, data);
                end
                "R": begin
                    code = $sscanf(line, "R %h %h %h", addr, reply, data);
                    check_fields(code, 3);
                    read_register(addr, reply, data);
                end
                "N": begin
                    code = $sscanf(line, "N %d %d %d", regions, dv, dd);
                    check_fields(code, 3);
                    run_bytes.delete();
                end
                "C": begin
                    code = $sscanf(line, "C %h", row);
                    check_fields(code, 1);
                    // leftmost byte is driven first
                    for (i = 0; i < NUM_CLASS; i++) begin
                        run_bytes.push_back(row[159 - 8*i -: 8]);
                    end
                    if (run_bytes.size() == regions * NUM_CLASS) begin
                        run_regions(regions, dv, dd);
                        read_results(model.size());
                        // a new burst starts over at entry 0
                        read_results(5);
                    end
                end
                default: begin
                    $display("unknown record kind in the stimulus file");
                    abort_run();
                end
            endcase
        end
        $fclose(fd);

        repeat (4) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cnn_test_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_test_top #(
    parameter int NUM_CLASS_BYTES = 20,
    parameter int SETTLE_CYCLES   = 28,
    parameter int BUFFER_DEPTH    = 2048
) (
    input  logic                      clk,
    input  logic                      reset,
    input  cnn_test_pkg::host_ctrl_t  host_ctrl,
    input  cnn_test_pkg::spi_cmd_t    host_cmd,
    input  logic                      cnn_ready,
    input  logic                      cnn_done,
    input  logic                      last_region,
    input  cnn_test_pkg::class_byte_t class_byte,
    input  logic                      spi_out,
    input  logic                      result_rd,
    output cnn_test_pkg::chip_spi_t   chip_spi,
    output logic [15:0]               spi_rdata,
    output logic                      seq_busy,
    output logic                      results_ready,
    output cnn_test_pkg::class_byte_t result_data
);

    import cnn_test_pkg::*;

    localparam int TIMER_W = $clog2(SETTLE_CYCLES + 1);

    spi_cmd_t           seq_cmd;
    logic               timer_load;
    logic               timer_done;
    logic [TIMER_W-1:0] load_value;
    logic               store;

    // serial link, shared by host and sequencer
    spi_config_shifter spi_config_shifter_i (
        .clk       (clk),
        .reset     (reset),
        .host_cmd  (host_cmd),
        .seq_cmd   (seq_cmd),
        .seq_busy  (seq_busy),
        .spi_out   (spi_out),
        .chip_spi  (chip_spi),
        .spi_rdata (spi_rdata)
    );

    readout_sequencer #(
        .NUM_CLASS_BYTES (NUM_CLASS_BYTES),
        .SETTLE_CYCLES   (SETTLE_CYCLES)
    ) readout_sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .host_ctrl     (host_ctrl),
        .cnn_ready     (cnn_ready),
        .cnn_done      (cnn_done),
        .last_region   (last_region),
        .timer_done    (timer_done),
        .seq_cmd       (seq_cmd),
        .seq_busy      (seq_busy),
        .timer_load    (timer_load),
        .load_value    (load_value),
        .store         (store),
        .results_ready (results_ready)
    );

    // wait between class request and sampling
    settle_timer #(
        .COUNT_W (TIMER_W)
    ) settle_timer_i (
        .clk        (clk),
        .reset      (reset),
        .timer_load (timer_load),
        .load_value (load_value),
        .timer_done (timer_done)
    );

    class_result_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) class_result_buffer_i (
        .clk         (clk),
        .reset       (reset),
        .store       (store),
        .class_byte  (class_byte),
        .result_rd   (result_rd),
        .result_data (result_data)
    );

endmodule

`default_nettype wire

// ==== design/class_result_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module class_result_buffer #(
    parameter int BUFFER_DEPTH = 2048
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      store,
    input  cnn_test_pkg::class_byte_t class_byte,
    input  logic                      result_rd,
    output cnn_test_pkg::class_byte_t result_data
);

    import cnn_test_pkg::*;

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);

    class_byte_t       mem [BUFFER_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////

    // write pointer survives between runs, only reset clears it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (store) begin
            if (wr_ptr == ADDR_W'(BUFFER_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // class byte sampled straight from the chip pins
    always_ff @(posedge clk) begin
        if (store) begin
            mem[wr_ptr] <= class_byte;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // host read side
    ////////////////////////////////////////////////////////////////////////////

    // every read burst starts over at entry 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (!result_rd) begin
            rd_ptr <= '0;
        end else if (rd_ptr == ADDR_W'(BUFFER_DEPTH - 1)) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // registered read, one cycle behind result_rd
    always_ff @(posedge clk) begin
        if (result_rd) begin
            result_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== design/settle_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module settle_timer #(
    parameter int COUNT_W = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               timer_load,
    input  logic [COUNT_W-1:0] load_value,
    output logic               timer_done
);

    logic [COUNT_W-1:0] count;

    // counts down to zero after a load
    // done rises on the load_value-th edge after the load edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count      <= '0;
            timer_done <= 1'b0;
        end else if (timer_load) begin
            // reload restarts a running count
            count      <= load_value;
            timer_done <= 1'b0;
        end else if (count != '0) begin
            count      <= count - 1'b1;
            timer_done <= (count == COUNT_W'(1));
        end else begin
            // silent at zero
            timer_done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/readout_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module readout_sequencer #(
    parameter int NUM_CLASS_BYTES = 20,
    parameter int SETTLE_CYCLES   = 28
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  cnn_test_pkg::host_ctrl_t             host_ctrl,
    input  logic                                 cnn_ready,
    input  logic                                 cnn_done,
    input  logic                                 last_region,
    input  logic                                 timer_done,
    output cnn_test_pkg::spi_cmd_t               seq_cmd,
    output logic                                 seq_busy,
    output logic                                 timer_load,
    output logic [$clog2(SETTLE_CYCLES+1)-1:0]   load_value,
    output logic                                 store,
    output logic                                 results_ready
);

    import cnn_test_pkg::*;

    localparam int IDX_W   = $clog2(NUM_CLASS_BYTES + 1);
    localparam int TIMER_W = $clog2(SETTLE_CYCLES + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_DONE,
        ST_WAIT_RESULT,
        ST_READ_CLASS,
        ST_SETTLE
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] class_idx;
    logic             last_flag;
    logic             ready_hold;
    logic [15:0]      sel_mode;

    // every sequencer write targets the mode register
    function automatic spi_cmd_t reg_write(input logic [15:0] data);
        spi_cmd_t c;
        c.wr         = 1'b1;
        c.rd         = 1'b0;
        c.frame.data = data;
        c.frame.addr = MODE_REG_ADDR;
        return c;
    endfunction

    // debug-valid wins over debug-data
    assign sel_mode = host_ctrl.dbg_valid ? MODE_DBG_VALID :
                      host_ctrl.dbg_data  ? MODE_DBG_DATA  : MODE_RUN;

    assign seq_busy   = (state != ST_IDLE);
    assign load_value = TIMER_W'(SETTLE_CYCLES);
    // byte is written on the edge right after the timer fires
    assign store      = (state == ST_SETTLE) && timer_done;

    ////////////////////////////////////////////////////////////////////////////
    // run state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            seq_cmd       <= '0;
            timer_load    <= 1'b0;
            class_idx     <= '0;
            last_flag     <= 1'b0;
            ready_hold    <= 1'b0;
            results_ready <= 1'b0;
        end else begin
            // write and load are single-cycle pulses
            seq_cmd    <= '0;
            timer_load <= 1'b0;
            if (!host_ctrl.start && state != ST_IDLE) begin
                // start dropped, abandon the run
                state         <= ST_IDLE;
                results_ready <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        results_ready <= 1'b0;
                        class_idx     <= '0;
                        last_flag     <= 1'b0;
                        ready_hold    <= 1'b0;
                        if (host_ctrl.start) begin
                            seq_cmd <= reg_write(MODE_RUN);
                            state   <= ST_WAIT_READY;
                        end
                    end
                    ST_WAIT_READY: begin
                        if (cnn_ready) begin
                            seq_cmd <= reg_write(sel_mode);
                            state   <= ST_WAIT_DONE;
                        end
                    end
                    ST_WAIT_DONE: begin
                        if (cnn_done) begin
                            seq_cmd <= reg_write(MODE_RUN);
                            state   <= ST_WAIT_RESULT;
                        end
                    end
                    ST_WAIT_RESULT: begin
                        class_idx <= '0;
                        if (cnn_ready) begin
                            state <= ST_READ_CLASS;
                        end else if (last_region) begin
                            // final region, no mode word afterwards
                            last_flag <= 1'b1;
                            state     <= ST_READ_CLASS;
                        end
                    end
                    ST_READ_CLASS: begin
                        if (class_idx < IDX_W'(NUM_CLASS_BYTES)) begin
                            // class request and timer load share the edge
                            seq_cmd    <= reg_write(16'(class_idx));
                            timer_load <= 1'b1;
                            state      <= ST_SETTLE;
                        end else if (last_flag) begin
                            // results_ready held two cycles for the host
                            results_ready <= 1'b1;
                            ready_hold    <= 1'b1;
                            if (ready_hold) begin
                                state <= ST_IDLE;
                            end
                        end else begin
                            seq_cmd <= reg_write(sel_mode);
                            state   <= ST_WAIT_DONE;
                        end
                    end
                    ST_SETTLE: begin
                        if (timer_done) begin
                            class_idx <= class_idx + 1'b1;
                            state     <= ST_READ_CLASS;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_config_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_config_shifter (
    input  logic                    clk,
    input  logic                    reset,
    input  cnn_test_pkg::spi_cmd_t  host_cmd,
    input  cnn_test_pkg::spi_cmd_t  seq_cmd,
    input  logic                    seq_busy,
    input  logic                    spi_out,
    output cnn_test_pkg::chip_spi_t chip_spi,
    output logic [15:0]             spi_rdata
);

    import cnn_test_pkg::*;

    // one-hot strobe travels the frame length plus one
    localparam int STROBE_W = FRAME_BITS + 1;
    localparam int WINDOW_W = 24;
    localparam int CNT_W    = $clog2(READ_BITS + 1);
    localparam logic [STROBE_W-1:0] STROBE_LOAD = {1'b1, {FRAME_BITS{1'b0}}};

    spi_cmd_t              cmd;
    logic [FRAME_BITS-1:0] frame_sr;
    logic [STROBE_W-1:0]   update_sr;
    logic [STROBE_W-1:0]   capture_sr;
    logic [CNT_W-1:0]      sample_cnt;
    logic [WINDOW_W-1:0]   window;
    logic                  rdata_pending;

    // sequencer owns the link during a run
    assign cmd = seq_busy ? seq_cmd : host_cmd;

    assign chip_spi = '{
        sdi:     frame_sr[0],
        update:  update_sr[0],
        capture: capture_sr[0]
    };

    ////////////////////////////////////////////////////////////////////////////
    // frame and strobe shifters
    ////////////////////////////////////////////////////////////////////////////

    // a new command restarts the shift, old frame is lost
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_sr   <= '0;
            update_sr  <= '0;
            capture_sr <= '0;
        end else if (cmd.wr) begin
            frame_sr   <= cmd.frame;
            update_sr  <= STROBE_LOAD;
            capture_sr <= '0;
        end else if (cmd.rd) begin
            // read frame carries the address only
            frame_sr   <= {16'd0, cmd.frame.addr};
            update_sr  <= '0;
            capture_sr <= STROBE_LOAD;
        end else begin
            frame_sr   <= frame_sr >> 1;
            update_sr  <= update_sr >> 1;
            capture_sr <= capture_sr >> 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback gathering
    ////////////////////////////////////////////////////////////////////////////

    // capture clears the window, then READ_BITS samples shift in at the top
    // idle counter parks at READ_BITS so nothing is sampled after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_cnt    <= CNT_W'(READ_BITS);
            window        <= '0;
            rdata_pending <= 1'b0;
            spi_rdata     <= '0;
        end else if (capture_sr[0]) begin
            sample_cnt    <= '0;
            window        <= '0;
            rdata_pending <= 1'b1;
        end else if (sample_cnt < CNT_W'(READ_BITS)) begin
            window     <= {spi_out, window[WINDOW_W-1:1]};
            sample_cnt <= sample_cnt + 1'b1;
        end else if (rdata_pending) begin
            // last 16 samples, earliest one lands in bit 0
            spi_rdata     <= window[WINDOW_W-1 -: 16];
            rdata_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/cnn_test_pkg.sv ====
`default_nettype none

package cnn_test_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // serial configuration link
    ////////////////////////////////////////////////////////////////////////////

    // address plus data, shifted out lsb first
    localparam int FRAME_BITS = 23;
    // reply samples taken after a capture strobe
    localparam int READ_BITS = 31;

    // one frame, address goes out first
    typedef struct packed {
        logic [15:0] data;
        logic [6:0]  addr;
    } cfg_frame_t;

    // one request to the shifter
    typedef struct packed {
        logic       wr;
        logic       rd;
        cfg_frame_t frame;
    } spi_cmd_t;

    // pins toward the chip
    typedef struct packed {
        logic sdi;
        logic update;
        logic capture;
    } chip_spi_t;

    ////////////////////////////////////////////////////////////////////////////
    // run control and chip mode words
    ////////////////////////////////////////////////////////////////////////////

    // start is a level, the selects pick the debug mode
    typedef struct packed {
        logic start;
        logic dbg_valid;
        logic dbg_data;
    } host_ctrl_t;

    localparam logic [6:0]  MODE_REG_ADDR  = 7'd58;
    localparam logic [15:0] MODE_RUN       = 16'h8000;
    localparam logic [15:0] MODE_DBG_VALID = 16'd313;
    localparam logic [15:0] MODE_DBG_DATA  = 16'd311;

    // class output of the chip
    typedef logic [7:0] class_byte_t;

endpackage

`default_nettype wire
